// File: Bender.yml
package:
  name: riscv_core_ex

export_include_dirs:
  - include

sources:
  - verilog/riscv_pkg.sv
  - verilog/riscv_ex_if.sv
  - verilog/riscv_mux.sv
  - verilog/riscv_ex_alu.sv
  - verilog/riscv_regfile.sv
  - verilog/riscv_idu.sv
  - verilog/riscv_exu.sv
  - verilog/riscv_core_ex.sv
  - target: test
    files:
      - tests/riscv_tb.sv

// File: include/riscv_params.svh
`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

// datapath
`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5
`define ALU_OPT_WIDTH   4
`define SRC_SEL_WIDTH   2

// alu operand pair codes
`define SRC_SEL_RS1_2   2'd0
`define SRC_SEL_RS1_IMM 2'd1
`define SRC_SEL_PC_4    2'd2
`define SRC_SEL_PC_IMM  2'd3

// major opcodes, rv32i base
`define OPC_OP          7'b0110011
`define OPC_OP_IMM      7'b0010011
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011

`endif

// File: project.f
+incdir+include
verilog/riscv_pkg.sv
verilog/riscv_ex_if.sv
verilog/riscv_mux.sv
verilog/riscv_ex_alu.sv
verilog/riscv_regfile.sv
verilog/riscv_idu.sv
verilog/riscv_exu.sv
verilog/riscv_core_ex.sv
tests/riscv_tb.sv

// File: tests/riscv_tb.sv
`include "riscv_params.svh"

module riscv_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int STIM_DELAY   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int DRAIN_LIMIT  = 20;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic        we;
    logic [31:0] data;
    logic        illegal;
    logic        redirect;
    logic [31:0] target;
  } retire_rec_t;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        retire_valid;
  logic [31:0] retire_pc;
  logic [4:0]  retire_rd;
  logic        retire_we;
  logic [31:0] retire_data;
  logic        retire_illegal;
  logic        redirect;
  logic [31:0] redirect_target;

  logic [31:0] model_regs [0:31];
  retire_rec_t exp_q [$];
  integer      seed;
  int          checks;
  int          errors;
  int          tests;
  logic [31:0] next_pc;

  riscv_core_ex i_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr_valid     (instr_valid),
    .instr           (instr),
    .pc              (pc),
    .retire_valid    (retire_valid),
    .retire_pc       (retire_pc),
    .retire_rd       (retire_rd),
    .retire_we       (retire_we),
    .retire_data     (retire_data),
    .retire_illegal  (retire_illegal),
    .redirect        (redirect),
    .redirect_target (redirect_target)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // mostly x0..x7 so dependencies are common
  function automatic logic [4:0] rand_reg();
    logic [31:0] r;
    r = $random(seed);
    if (r[1:0] != 2'b11) return {2'b00, r[4:2]};
    return r[8:4];
  endfunction

  function automatic logic [31:0] gen_alu(input logic [4:0] rd, rs1, rs2);
    logic [31:0] r;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    r   = $random(seed);
    f3  = r[2:0];
    alt = r[3] && (f3 == 3'd0 || f3 == 3'd5);
    if (r[4]) return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `OPC_OP};
    imm = r[31:20];
    if (f3 == 3'd1) imm = {7'b0, r[24:20]};
    else if (f3 == 3'd5) imm = {1'b0, r[3], 5'b0, r[24:20]};  // srli / srai
    return {imm, rs1, f3, rd, `OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // isa reference model in program order
  task automatic model_exec(input logic [31:0] w, input logic [31:0] pc_v,
                            output retire_rec_t rec);
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    rd    = w[11:7];
    f3    = w[14:12];
    a     = model_regs[w[19:15]];
    b     = model_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'b0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    rec       = '0;
    rec.valid = 1'b1;
    rec.pc    = pc_v;
    rec.rd    = rd;
    case (w[6:0])
      `OPC_OP:     {rec.we, rec.data} = {1'b1, alu_ref(f3, w[30], a, b)};
      `OPC_OP_IMM: {rec.we, rec.data} = {1'b1, alu_ref(f3, f3 == 3'd5 && w[30], a, imm_i)};
      `OPC_LUI:    {rec.we, rec.data} = {1'b1, imm_u};
      `OPC_AUIPC:  {rec.we, rec.data} = {1'b1, pc_v + imm_u};
      `OPC_JAL: begin
        {rec.we, rec.data, rec.redirect} = {1'b1, pc_v + 32'd4, 1'b1};
        rec.target = pc_v + imm_j;
      end
      `OPC_JALR: begin
        {rec.we, rec.data, rec.redirect} = {1'b1, pc_v + 32'd4, 1'b1};
        rec.target = (a + imm_i) & ~32'h1;
      end
      `OPC_BRANCH: begin
        case (f3)
          3'd0:    rec.redirect = (a == b);
          3'd1:    rec.redirect = (a != b);
          3'd4:    rec.redirect = ($signed(a) < $signed(b));
          3'd5:    rec.redirect = ($signed(a) >= $signed(b));
          3'd6:    rec.redirect = (a < b);
          3'd7:    rec.redirect = (a >= b);
          default: rec.redirect = 1'b0;
        endcase
        rec.target = pc_v + imm_b;
      end
      default: rec.illegal = 1'b1;
    endcase
    if (rec.we && rd != 5'd0) model_regs[rd] = rec.data;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_retire();
    retire_rec_t e;
    if (exp_q.size() < 2) return;
    e = exp_q.pop_front();
    check_val("retire_valid", retire_valid, e.valid);
    check_val("retire_illegal", retire_illegal, e.illegal);
    check_val("retire_we", retire_we, e.we);
    check_val("redirect", redirect, e.redirect);
    if (e.valid) check_val("retire_pc", retire_pc, e.pc);
    if (e.we) begin
      check_val("retire_rd", retire_rd, e.rd);
      check_val("retire_data", retire_data, e.data);
    end
    if (e.redirect) check_val("redirect_target", redirect_target, e.target);
  endtask

  // check the record due now and drive the next word
  task automatic step(input logic valid, input logic [31:0] w);
    retire_rec_t rec;
    @(posedge clk);
    #STIM_DELAY;
    compare_retire();
    instr_valid = valid;
    instr       = w;
    pc          = next_pc;
    rec         = '0;
    if (valid) begin
      model_exec(w, next_pc, rec);
      next_pc += 32'd4;
    end
    exp_q.push_back(rec);
  endtask

  function automatic bit queue_busy();
    foreach (exp_q[i]) if (exp_q[i].valid) return 1'b1;
    return 1'b0;
  endfunction

  task automatic drain();
    int n;
    n = 0;
    while (queue_busy() && n < DRAIN_LIMIT) begin
      step(1'b0, 32'h0);
      n++;
    end
    if (queue_busy()) begin
      $display("Error at %0t: retire records still pending after %0d cycles", $time, n);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int err_start);
    drain();
    tests++;
    $display("test %s finished with %0d errors", name, errors - err_start);
  endtask

  // the +0x800 undoes the addi sign extension
  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = (value + 32'h800) >> 12;
    step(1'b1, {upper[19:0], rd, `OPC_LUI});
    step(1'b1, {value[11:0], rd, 3'b000, rd, `OPC_OP_IMM});
  endtask

  function automatic logic [31:0] pick_operand(input logic [2:0] k);
    case (k)
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'h0000_0001;
      3'd2:    return 32'hffff_ffff;
      3'd3:    return 32'h7fff_ffff;
      3'd4:    return 32'h8000_0000;
      3'd5:    return 32'h8000_0001;
      3'd6:    return 32'h0000_0002;
      default: return $random(seed);
    endcase
  endfunction

  function automatic logic [6:0] illegal_opc(input logic [2:0] k);
    case (k)
      3'd0:    return 7'b0000011;  // load
      3'd1:    return 7'b0100011;  // store
      3'd2:    return 7'b1110011;  // system
      3'd3:    return 7'b0001111;  // fence
      3'd4:    return 7'b1111111;
      default: return 7'b0000000;
    endcase
  endfunction

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  prev1;
    logic [4:0]  prev2;
    logic [2:0]  f3;
    int          err_start;
    int          lat;
    logic        seen;

    seed        = 32'h2b5c;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    next_pc     = 32'h0000_1000;
    checks      = 0;
    errors      = 0;
    tests       = 0;
    foreach (model_regs[i]) model_regs[i] = '0;

    err_start = errors;
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(posedge clk);
      #STIM_DELAY;
      check_val("retire_valid", retire_valid, 0);
      check_val("retire_we", retire_we, 0);
      check_val("retire_illegal", retire_illegal, 0);
      check_val("redirect", redirect, 0);
    end
    rst_n = 1'b1;
    tests++;
    $display("test reset finished with %0d errors", errors - err_start);

    err_start = errors;
    for (int i = 1; i < 8; i++) load_reg(i[4:0], $random(seed));
    for (int i = 0; i < 200; i++) step(1'b1, gen_alu(rand_reg(), rand_reg(), rand_reg()));
    end_test("alu_ops", err_start);

    err_start = errors;
    prev1 = 5'd1;
    prev2 = 5'd2;
    for (int i = 0; i < 150; i++) begin
      r   = $random(seed);
      rs1 = r[0] ? prev1 : prev2;
      rs2 = r[1] ? prev1 : prev2;
      rd  = {2'b00, r[4:2]};  // x0 included
      step(1'b1, gen_alu(rd, rs1, rs2));
      prev2 = prev1;
      prev1 = rd;
    end
    end_test("dependencies", err_start);

    err_start = errors;
    for (int i = 0; i < 60; i++) begin
      r = $random(seed);
      load_reg(5'd1, pick_operand(r[2:0]));
      load_reg(5'd2, r[9] ? pick_operand(r[2:0]) : pick_operand(r[5:3]));
      f3 = r[8:6];
      if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;
      rs2 = r[10] ? 5'd1 : 5'd2;
      r2  = $random(seed);
      step(1'b1, {r2[12], r2[10:5], rs2, 5'd1, f3, r2[4:1], r2[11], `OPC_BRANCH});
    end
    end_test("branches", err_start);

    err_start = errors;
    for (int i = 0; i < 100; i++) begin
      r  = $random(seed);
      r2 = $random(seed);
      rd = rand_reg();
      case (r[1:0])
        2'd0: step(1'b1, {r2[31:12], rd, `OPC_LUI});
        2'd1: step(1'b1, {r2[31:12], rd, `OPC_AUIPC});
        2'd2: step(1'b1, {r2[20], r2[10:1], r2[11], r2[19:12], rd, `OPC_JAL});
        default: step(1'b1, {r2[31:20], rand_reg(), 3'b000, rd, `OPC_JALR});
      endcase
    end
    end_test("jumps_upper", err_start);

    err_start = errors;
    for (int i = 0; i < 60; i++) begin
      r = $random(seed);
      if (r[0]) step(1'b1, gen_alu(rand_reg(), rand_reg(), rand_reg()));
      else step(1'b0, $random(seed));  // idle word is ignored
    end
    for (int i = 0; i < 10; i++) begin
      drain();
      step(1'b1, gen_alu(rand_reg(), rand_reg(), rand_reg()));
      lat  = 0;
      seen = 1'b0;
      while (!seen && lat < 8) begin
        step(1'b0, 32'h0);
        lat++;
        seen = retire_valid;
      end
      check_val("retire latency", lat, 2);
    end
    end_test("latency_gaps", err_start);

    err_start = errors;
    for (int i = 0; i < 40; i++) begin
      r  = $random(seed);
      rd = (r[2:0] == 3'd0) ? 5'd1 : {2'b00, r[2:0]};
      load_reg(rd, $random(seed));
      step(1'b1, {r[31:12], rd, illegal_opc(r[5:3])});
      step(1'b1, {12'd0, rd, 3'b000, 5'd8, `OPC_OP_IMM});  // old rd value
    end
    end_test("illegal_ops", err_start);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: verilog/riscv_core_ex.sv
`include "riscv_params.svh"

module riscv_core_ex (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       instr_valid,
  input  logic [`DATA_WIDTH-1:0]     instr,
  input  logic [`DATA_WIDTH-1:0]     pc,
  output logic                       retire_valid,
  output logic [`DATA_WIDTH-1:0]     retire_pc,
  output logic [`REG_ADDR_WIDTH-1:0] retire_rd,
  output logic                       retire_we,
  output logic [`DATA_WIDTH-1:0]     retire_data,
  output logic                       retire_illegal,
  output logic                       redirect,
  output logic [`DATA_WIDTH-1:0]     redirect_target
);

  logic [`REG_ADDR_WIDTH-1:0] rs1_addr;
  logic [`REG_ADDR_WIDTH-1:0] rs2_addr;
  logic [`DATA_WIDTH-1:0]     rs1_data;
  logic [`DATA_WIDTH-1:0]     rs2_data;
  logic                       fwd_we;
  logic [`REG_ADDR_WIDTH-1:0] fwd_rd;
  logic [`DATA_WIDTH-1:0]     fwd_data;

  riscv_ex_if ex_if ();

  riscv_idu i_idu (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .fwd_we      (fwd_we),
    .fwd_rd      (fwd_rd),
    .fwd_data    (fwd_data),
    .retire_we   (retire_we),
    .retire_rd   (retire_rd),
    .retire_data (retire_data),
    .ex          (ex_if.idu)
  );

  riscv_exu i_exu (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex              (ex_if.exu),
    .fwd_we          (fwd_we),
    .fwd_rd          (fwd_rd),
    .fwd_data        (fwd_data),
    .retire_valid    (retire_valid),
    .retire_pc       (retire_pc),
    .retire_rd       (retire_rd),
    .retire_we       (retire_we),
    .retire_data     (retire_data),
    .retire_illegal  (retire_illegal),
    .redirect        (redirect),
    .redirect_target (redirect_target)
  );

  // write port fed from the retire stage
  riscv_regfile i_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (retire_we),
    .wr_addr  (retire_rd),
    .wr_data  (retire_data)
  );

endmodule

// File: verilog/riscv_ex_alu.sv
`include "riscv_params.svh"

module riscv_ex_alu (
  input  riscv_pkg::alu_opt_e     alu_opt,
  input  logic [`DATA_WIDTH-1:0]  alu_a_data,
  input  logic [`DATA_WIDTH-1:0]  alu_b_data,
  output logic                    carry_flag,
  output logic                    less_flag,
  output logic [`DATA_WIDTH-1:0]  alu_out_data
);

  logic [`DATA_WIDTH:0] diff;
  logic [4:0]           shamt;

  assign diff       = {1'b0, alu_a_data} - {1'b0, alu_b_data};
  assign carry_flag = diff[`DATA_WIDTH];  // unsigned borrow
  assign less_flag  = $signed(alu_a_data) < $signed(alu_b_data);
  assign shamt      = alu_b_data[4:0];

  always_comb begin
    case (alu_opt)
      riscv_pkg::ALU_ADD:  alu_out_data = alu_a_data + alu_b_data;
      riscv_pkg::ALU_SUB:  alu_out_data = diff[`DATA_WIDTH-1:0];
      riscv_pkg::ALU_SLL:  alu_out_data = alu_a_data << shamt;
      riscv_pkg::ALU_SLT:  alu_out_data = `DATA_WIDTH'(less_flag);
      riscv_pkg::ALU_SLTU: alu_out_data = `DATA_WIDTH'(carry_flag);
      riscv_pkg::ALU_XOR:  alu_out_data = alu_a_data ^ alu_b_data;
      riscv_pkg::ALU_SRL:  alu_out_data = alu_a_data >> shamt;
      riscv_pkg::ALU_SRA:  alu_out_data = $signed(alu_a_data) >>> shamt;
      riscv_pkg::ALU_OR:   alu_out_data = alu_a_data | alu_b_data;
      riscv_pkg::ALU_AND:  alu_out_data = alu_a_data & alu_b_data;
      default:             alu_out_data = '0;
    endcase
  end

endmodule

// File: verilog/riscv_ex_if.sv
// decoded bundle, stage-one register to execute
interface riscv_ex_if;

  logic               valid;  // one cycle per instruction
  riscv_pkg::dec_op_t op;

  modport idu (
    output valid,
    output op
  );

  modport exu (
    input valid,
    input op
  );

endinterface

// File: verilog/riscv_exu.sv
`include "riscv_params.svh"

module riscv_exu (
  input  logic                       clk,
  input  logic                       rst_n,
  riscv_ex_if.exu                    ex,
  output logic                       fwd_we,
  output logic [`REG_ADDR_WIDTH-1:0] fwd_rd,
  output logic [`DATA_WIDTH-1:0]     fwd_data,
  output logic                       retire_valid,
  output logic [`DATA_WIDTH-1:0]     retire_pc,
  output logic [`REG_ADDR_WIDTH-1:0] retire_rd,
  output logic                       retire_we,
  output logic [`DATA_WIDTH-1:0]     retire_data,
  output logic                       retire_illegal,
  output logic                       redirect,
  output logic [`DATA_WIDTH-1:0]     redirect_target
);

  riscv_pkg::dec_op_t     op;
  logic [`DATA_WIDTH-1:0] alu_a_data;
  logic [`DATA_WIDTH-1:0] alu_b_data;
  logic [`DATA_WIDTH-1:0] alu_out_data;
  logic                   carry_flag;
  logic                   less_flag;
  logic                   zero_flag;
  logic                   taken;
  logic [`DATA_WIDTH-1:0] target_sum;
  logic [`DATA_WIDTH-1:0] target;

  assign op = ex.op;

  riscv_mux #(
    .NR_KEY   (4),
    .KEY_LEN  (`SRC_SEL_WIDTH),
    .DATA_LEN (2*`DATA_WIDTH)
  ) i_mux_src_sel (
    .key         (op.src_sel),
    .default_out ('0),
    .lut         ({`SRC_SEL_RS1_2,   {op.src1, op.src2},
                   `SRC_SEL_RS1_IMM, {op.src1, op.imm},
                   `SRC_SEL_PC_4,    {op.pc,   `DATA_WIDTH'(4)},
                   `SRC_SEL_PC_IMM,  {op.pc,   op.imm}}),
    .out         ({alu_a_data, alu_b_data})
  );

  riscv_ex_alu i_alu (
    .alu_opt      (op.alu_opt),
    .alu_a_data   (alu_a_data),
    .alu_b_data   (alu_b_data),
    .carry_flag   (carry_flag),
    .less_flag    (less_flag),
    .alu_out_data (alu_out_data)
  );

  assign zero_flag = ~(|alu_out_data);

  // non-branch keys fall to zero
  riscv_mux #(
    .NR_KEY   (6),
    .KEY_LEN  (4),
    .DATA_LEN (1)
  ) i_mux_branch (
    .key         ({op.branch, op.funct3}),
    .default_out (1'b0),
    .lut         ({4'b1000, zero_flag,     // beq
                   4'b1001, ~zero_flag,    // bne
                   4'b1100, less_flag,     // blt
                   4'b1101, ~less_flag,    // bge
                   4'b1110, carry_flag,    // bltu
                   4'b1111, ~carry_flag}), // bgeu
    .out         (taken)
  );

  assign target_sum = (op.jalr ? op.src1 : op.pc) + op.imm;
  assign target     = {target_sum[`DATA_WIDTH-1:1], target_sum[0] & ~op.jalr};

  assign fwd_we   = ex.valid & op.rd_we;
  assign fwd_rd   = op.rd;
  assign fwd_data = alu_out_data;

  // stage-two register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_valid   <= 1'b0;
      retire_we      <= 1'b0;
      retire_illegal <= 1'b0;
      redirect       <= 1'b0;
    end else begin
      retire_valid   <= ex.valid;
      retire_we      <= fwd_we;
      retire_illegal <= ex.valid & op.illegal;
      redirect       <= ex.valid & (op.jump | taken);
    end
  end

  always_ff @(posedge clk) begin
    retire_pc       <= op.pc;
    retire_rd       <= op.rd;
    retire_data     <= alu_out_data;
    redirect_target <= target;
  end

endmodule

// File: verilog/riscv_idu.sv
`include "riscv_params.svh"

module riscv_idu (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       instr_valid,
  input  riscv_pkg::instr_t          instr,
  input  logic [`DATA_WIDTH-1:0]     pc,
  input  logic [`DATA_WIDTH-1:0]     rs1_data,
  input  logic [`DATA_WIDTH-1:0]     rs2_data,
  output logic [`REG_ADDR_WIDTH-1:0] rs1_addr,
  output logic [`REG_ADDR_WIDTH-1:0] rs2_addr,
  input  logic                       fwd_we,
  input  logic [`REG_ADDR_WIDTH-1:0] fwd_rd,
  input  logic [`DATA_WIDTH-1:0]     fwd_data,
  input  logic                       retire_we,
  input  logic [`REG_ADDR_WIDTH-1:0] retire_rd,
  input  logic [`DATA_WIDTH-1:0]     retire_data,
  riscv_ex_if.idu                    ex
);

  riscv_pkg::dec_op_t     dec;
  logic [`DATA_WIDTH-1:0] imm_i;
  logic [`DATA_WIDTH-1:0] imm_b;
  logic [`DATA_WIDTH-1:0] imm_u;
  logic [`DATA_WIDTH-1:0] imm_j;
  logic [`DATA_WIDTH-1:0] src1_fwd;
  logic [`DATA_WIDTH-1:0] src2_fwd;
  logic                   alt_op;
  logic                   alt_imm;

  assign rs1_addr = instr.r.rs1;
  assign rs2_addr = instr.r.rs2;

  // immediates from the format views
  assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                  instr.b.imm10_5, instr.b.imm4_1, 1'b0};
  assign imm_u = {instr.u.imm31_12, 12'b0};
  assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                  instr.j.imm11, instr.j.imm10_1, 1'b0};

  // funct7[5] selects sub/sra, only meaningful for some funct3
  assign alt_op  = instr.r.funct7[5] &
                   (instr.r.funct3 == 3'b000 || instr.r.funct3 == 3'b101);
  assign alt_imm = instr.r.funct7[5] & (instr.r.funct3 == 3'b101);

  // execute result wins over the retiring one
  always_comb begin
    if (rs1_addr == '0)                            src1_fwd = '0;
    else if (fwd_we && fwd_rd == rs1_addr)         src1_fwd = fwd_data;
    else if (retire_we && retire_rd == rs1_addr)   src1_fwd = retire_data;
    else                                           src1_fwd = rs1_data;
  end

  always_comb begin
    if (rs2_addr == '0)                            src2_fwd = '0;
    else if (fwd_we && fwd_rd == rs2_addr)         src2_fwd = fwd_data;
    else if (retire_we && retire_rd == rs2_addr)   src2_fwd = retire_data;
    else                                           src2_fwd = rs2_data;
  end

  always_comb begin
    dec         = '0;
    dec.rd      = instr.r.rd;
    dec.funct3  = instr.r.funct3;
    dec.pc      = pc;
    dec.src1    = src1_fwd;
    dec.src2    = src2_fwd;
    dec.alu_opt = riscv_pkg::ALU_ADD;
    dec.src_sel = `SRC_SEL_RS1_2;
    case (instr.r.opcode)
      `OPC_OP: begin
        dec.rd_we   = 1'b1;
        dec.alu_opt = riscv_pkg::alu_opt_e'({alt_op, instr.r.funct3});
      end
      `OPC_OP_IMM: begin
        dec.rd_we   = 1'b1;
        dec.src_sel = `SRC_SEL_RS1_IMM;
        dec.imm     = imm_i;
        dec.alu_opt = riscv_pkg::alu_opt_e'({alt_imm, instr.r.funct3});
      end
      `OPC_LUI: begin
        dec.rd_we   = 1'b1;
        dec.src_sel = `SRC_SEL_RS1_IMM;
        dec.src1    = '0;  // 0 + imm
        dec.imm     = imm_u;
      end
      `OPC_AUIPC: begin
        dec.rd_we   = 1'b1;
        dec.src_sel = `SRC_SEL_PC_IMM;
        dec.imm     = imm_u;
      end
      `OPC_JAL: begin
        dec.rd_we   = 1'b1;
        dec.src_sel = `SRC_SEL_PC_4;  // link value
        dec.jump    = 1'b1;
        dec.imm     = imm_j;
      end
      `OPC_JALR: begin
        dec.rd_we   = 1'b1;
        dec.src_sel = `SRC_SEL_PC_4;
        dec.jump    = 1'b1;
        dec.jalr    = 1'b1;
        dec.imm     = imm_i;
      end
      `OPC_BRANCH: begin
        dec.branch  = 1'b1;
        dec.alu_opt = riscv_pkg::ALU_SUB;  // flags decide the branch
        dec.imm     = imm_b;
      end
      default: dec.illegal = 1'b1;
    endcase
  end

  // stage-one register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex.valid <= 1'b0;
    end else begin
      ex.valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    ex.op <= dec;
  end

endmodule

// File: verilog/riscv_mux.sv
module riscv_mux #(
  parameter int NR_KEY   = 2,
  parameter int KEY_LEN  = 1,
  parameter int DATA_LEN = 1
) (
  input  logic [KEY_LEN-1:0]                   key,
  input  logic [DATA_LEN-1:0]                  default_out,
  input  logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] lut,
  output logic [DATA_LEN-1:0]                  out
);

  localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

  // first pair sits at the msb end of lut
  always_comb begin
    out = default_out;
    for (int i = 0; i < NR_KEY; i++) begin
      if (lut[i*PAIR_LEN+DATA_LEN +: KEY_LEN] == key) begin
        out = lut[i*PAIR_LEN +: DATA_LEN];
      end
    end
  end

endmodule

// File: verilog/riscv_pkg.sv
`include "riscv_params.svh"

package riscv_pkg;

  // instruction formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } instr_b_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_u_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_j_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
    instr_b_t b;
    instr_u_t u;
    instr_j_t j;
  } instr_t;

  // encoded as {funct7[5], funct3}
  typedef enum logic [`ALU_OPT_WIDTH-1:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_opt_e;

  typedef struct packed {
    logic                       illegal;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic                       rd_we;
    logic [`SRC_SEL_WIDTH-1:0]  src_sel;
    alu_opt_e                   alu_opt;
    logic                       branch;
    logic [2:0]                 funct3;
    logic                       jump;
    logic                       jalr;
    logic [`DATA_WIDTH-1:0]     imm;
    logic [`DATA_WIDTH-1:0]     pc;
    logic [`DATA_WIDTH-1:0]     src1;   // forwarded
    logic [`DATA_WIDTH-1:0]     src2;   // forwarded
  } dec_op_t;

endpackage

// File: verilog/riscv_regfile.sv
`include "riscv_params.svh"

module riscv_regfile (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`REG_ADDR_WIDTH-1:0] rs1_addr,
  input  logic [`REG_ADDR_WIDTH-1:0] rs2_addr,
  output logic [`DATA_WIDTH-1:0]     rs1_data,
  output logic [`DATA_WIDTH-1:0]     rs2_data,
  input  logic                       we,
  input  logic [`REG_ADDR_WIDTH-1:0] wr_addr,
  input  logic [`DATA_WIDTH-1:0]     wr_data
);

  localparam int NR_REGS = 1 << `REG_ADDR_WIDTH;

  // x0 has no storage
  logic [`DATA_WIDTH-1:0] regs [1:NR_REGS-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < NR_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule
